/* hdl/csr_decode.sv */
// csr address decode
// maps the address to a register select and checks existence,
// privilege and read-only rules; an illegal access never writes

`timescale 1ns/1ps
`default_nettype none

module csr_decode (
  input  wire csr_types_pkg::csr_addr_t csr_addr,
  input  wire logic                     csr_access,
  input  wire logic                     csr_we,
  input  wire csr_types_pkg::priv_t     current_priv,
  output csr_types_pkg::csr_id_t        csr_sel,
  output logic                          csr_wr_en,
  output logic                          illegal_csr
);

  import csr_types_pkg::*;
  import csr_map_pkg::*;

  logic [1:0] addr_priv;   // minimum privilege, addr[9:8]
  logic       read_only;
  logic       priv_low;

  // address to register id
  always_comb begin
    unique case (csr_addr)
      CSR_MSTATUS:   csr_sel = ID_MSTATUS;
      CSR_MISA:      csr_sel = ID_MISA;
      CSR_MIE:       csr_sel = ID_MIE;
      CSR_MTVEC:     csr_sel = ID_MTVEC;
      CSR_MSCRATCH:  csr_sel = ID_MSCRATCH;
      CSR_MEPC:      csr_sel = ID_MEPC;
      CSR_MCAUSE:    csr_sel = ID_MCAUSE;
      CSR_MTVAL:     csr_sel = ID_MTVAL;
      CSR_MIP:       csr_sel = ID_MIP;
      CSR_MVENDORID: csr_sel = ID_MVENDORID;
      CSR_MARCHID:   csr_sel = ID_MARCHID;
      CSR_MIMPID:    csr_sel = ID_MIMPID;
      CSR_MHARTID:   csr_sel = ID_MHARTID;
      default:       csr_sel = ID_NONE;  // not implemented
    endcase
  end

  // ====================
  // legality
  assign addr_priv = csr_addr[9:8];
  assign priv_low  = (current_priv < addr_priv);
  // 0xcxx-0xfxx are read-only by encoding, misa is read-only here
  assign read_only = (csr_addr[11:10] == 2'b11) || (csr_addr == CSR_MISA);

  assign illegal_csr = csr_access &&
                       ((csr_sel == ID_NONE) || priv_low || (csr_we && read_only));

  // suppressed whenever the check fails
  assign csr_wr_en = csr_we && csr_access && !illegal_csr;

endmodule

`default_nettype wire

/* hdl/csr_file.sv */
// machine-mode csr file, top level
// csr instruction access with legality check, trap entry, mret
// and the machine interrupt registers

`timescale 1ns/1ps
`default_nettype none

module csr_file (
  input  wire                         clk,
  input  wire                         reset_n,
  // csr instruction port
  input  wire csr_types_pkg::csr_addr_t csr_addr,
  input  wire csr_types_pkg::xlen_t   csr_wdata,
  input  wire csr_types_pkg::csr_op_t csr_op,
  input  wire logic                   csr_we,
  input  wire logic                   csr_access,
  input  wire csr_types_pkg::priv_t   current_priv,
  output csr_types_pkg::xlen_t        csr_rdata,
  output logic                        illegal_csr,
  // trap port
  input  wire logic                   trap_entry,
  input  wire csr_types_pkg::xlen_t   trap_pc,
  input  wire csr_types_pkg::cause_t  trap_cause,
  input  wire logic                   trap_is_interrupt,
  input  wire csr_types_pkg::xlen_t   trap_val,
  output csr_types_pkg::xlen_t        trap_vector,   // handler base, = mtvec
  // trap return
  input  wire logic                   mret,
  output csr_types_pkg::xlen_t        mepc_out,
  // status
  output logic                        mstatus_mie,
  output logic                        mstatus_mpie,
  output csr_types_pkg::priv_t        mpp_out,
  // interrupt pins and state
  input  wire logic                   mtip_in,
  input  wire logic                   msip_in,
  input  wire logic                   meip_in,
  output csr_types_pkg::xlen_t        mip_out,
  output csr_types_pkg::xlen_t        mie_out
);

  import csr_types_pkg::*;

  csr_id_t csr_sel;
  logic    csr_wr_en;      // gated by the legality check
  xlen_t   csr_wr_value;
  xlen_t   mstatus_val;
  xlen_t   mscratch_val;
  xlen_t   mcause_val;
  xlen_t   mtval_val;

  // ====================
  // access path
  csr_decode u_decode (
    .csr_addr     (csr_addr),
    .csr_access   (csr_access),
    .csr_we       (csr_we),
    .current_priv (current_priv),
    .csr_sel      (csr_sel),
    .csr_wr_en    (csr_wr_en),
    .illegal_csr  (illegal_csr)
  );

  csr_rw_datapath u_datapath (
    .csr_sel      (csr_sel),
    .csr_op       (csr_op),
    .csr_wdata    (csr_wdata),
    .mstatus_val  (mstatus_val),
    .mie_val      (mie_out),
    .mip_val      (mip_out),
    .mtvec_val    (trap_vector),
    .mscratch_val (mscratch_val),
    .mepc_val     (mepc_out),
    .mcause_val   (mcause_val),
    .mtval_val    (mtval_val),
    .csr_rdata    (csr_rdata),
    .csr_wr_value (csr_wr_value)
  );

  // ====================
  // register blocks
  mstatus_reg u_mstatus (
    .clk          (clk),
    .reset_n      (reset_n),
    .csr_sel      (csr_sel),
    .csr_wr_en    (csr_wr_en),
    .csr_wr_value (csr_wr_value),
    .trap_entry   (trap_entry),
    .mret         (mret),
    .current_priv (current_priv),
    .mstatus_val  (mstatus_val),
    .mstatus_mie  (mstatus_mie),
    .mstatus_mpie (mstatus_mpie),
    .mpp_out      (mpp_out)
  );

  trap_regs u_trap_regs (
    .clk               (clk),
    .reset_n           (reset_n),
    .csr_sel           (csr_sel),
    .csr_wr_en         (csr_wr_en),
    .csr_wr_value      (csr_wr_value),
    .trap_entry        (trap_entry),
    .trap_pc           (trap_pc),
    .trap_val          (trap_val),
    .trap_cause        (trap_cause),
    .trap_is_interrupt (trap_is_interrupt),
    .mtvec_val         (trap_vector),
    .mscratch_val      (mscratch_val),
    .mepc_val          (mepc_out),
    .mcause_val        (mcause_val),
    .mtval_val         (mtval_val)
  );

  irq_regs u_irq_regs (
    .clk          (clk),
    .reset_n      (reset_n),
    .csr_sel      (csr_sel),
    .csr_wr_en    (csr_wr_en),
    .csr_wr_value (csr_wr_value),
    .mtip_in      (mtip_in),
    .msip_in      (msip_in),
    .meip_in      (meip_in),
    .mie_val      (mie_out),
    .mip_val      (mip_out)   // pins pass through combinationally
  );

endmodule

`default_nettype wire

/* hdl/csr_map_pkg.sv */
// csr address map
// machine-mode register addresses and the field positions
// inside mstatus, mie and mip

`default_nettype none

package csr_map_pkg;

  // ====================
  // addresses
  localparam csr_types_pkg::csr_addr_t CSR_MSTATUS   = 12'h300;
  localparam csr_types_pkg::csr_addr_t CSR_MISA      = 12'h301;  // read-only here
  localparam csr_types_pkg::csr_addr_t CSR_MIE       = 12'h304;
  localparam csr_types_pkg::csr_addr_t CSR_MTVEC     = 12'h305;
  localparam csr_types_pkg::csr_addr_t CSR_MSCRATCH  = 12'h340;
  localparam csr_types_pkg::csr_addr_t CSR_MEPC      = 12'h341;
  localparam csr_types_pkg::csr_addr_t CSR_MCAUSE    = 12'h342;
  localparam csr_types_pkg::csr_addr_t CSR_MTVAL     = 12'h343;
  localparam csr_types_pkg::csr_addr_t CSR_MIP       = 12'h344;
  // identity block, all in the 0xfxx read-only range
  localparam csr_types_pkg::csr_addr_t CSR_MVENDORID = 12'hF11;
  localparam csr_types_pkg::csr_addr_t CSR_MARCHID   = 12'hF12;
  localparam csr_types_pkg::csr_addr_t CSR_MIMPID    = 12'hF13;
  localparam csr_types_pkg::csr_addr_t CSR_MHARTID   = 12'hF14;

  // ====================
  // mstatus fields
  localparam int MSTATUS_MIE_BIT  = 3;
  localparam int MSTATUS_MPIE_BIT = 7;
  localparam int MSTATUS_MPP_LSB  = 11;
  localparam int MSTATUS_MPP_MSB  = 12;

  // ====================
  // mie / mip bit positions
  localparam int IRQ_MSI_BIT = 3;   // software
  localparam int IRQ_MTI_BIT = 7;   // timer
  localparam int IRQ_MEI_BIT = 11;  // external

  // pending bits owned by the interrupt pins
  localparam csr_types_pkg::xlen_t MIP_HW_MASK =
    (csr_types_pkg::xlen_t'(1) << IRQ_MSI_BIT) |
    (csr_types_pkg::xlen_t'(1) << IRQ_MTI_BIT) |
    (csr_types_pkg::xlen_t'(1) << IRQ_MEI_BIT);

endpackage

`default_nettype wire

/* hdl/csr_rw_datapath.sv */
// csr read mux and read-modify-write value
// selects the addressed register, supplies the hardwired identity
// words and forms the write/set/clear result

`timescale 1ns/1ps
`default_nettype none

`include "csr_cfg.svh"

module csr_rw_datapath (
  input  wire csr_types_pkg::csr_id_t csr_sel,
  input  wire csr_types_pkg::csr_op_t csr_op,
  input  wire csr_types_pkg::xlen_t   csr_wdata,    // rs1 or zero-extended uimm
  input  wire csr_types_pkg::xlen_t   mstatus_val,
  input  wire csr_types_pkg::xlen_t   mie_val,
  input  wire csr_types_pkg::xlen_t   mip_val,
  input  wire csr_types_pkg::xlen_t   mtvec_val,
  input  wire csr_types_pkg::xlen_t   mscratch_val,
  input  wire csr_types_pkg::xlen_t   mepc_val,
  input  wire csr_types_pkg::xlen_t   mcause_val,
  input  wire csr_types_pkg::xlen_t   mtval_val,
  output csr_types_pkg::xlen_t        csr_rdata,
  output csr_types_pkg::xlen_t        csr_wr_value
);

  import csr_types_pkg::*;

  // ====================
  // read mux
  always_comb begin
    unique case (csr_sel)
      ID_MSTATUS:   csr_rdata = mstatus_val;
      ID_MISA:      csr_rdata = `CSR_MISA_VALUE;
      ID_MIE:       csr_rdata = mie_val;
      ID_MTVEC:     csr_rdata = mtvec_val;
      ID_MSCRATCH:  csr_rdata = mscratch_val;
      ID_MEPC:      csr_rdata = mepc_val;
      ID_MCAUSE:    csr_rdata = mcause_val;
      ID_MTVAL:     csr_rdata = mtval_val;
      ID_MIP:       csr_rdata = mip_val;         // includes live pin state
      ID_MIMPID:    csr_rdata = `CSR_MIMPID_VALUE;
      default:      csr_rdata = '0;  // vendor, arch, hart id and unknown read 0
    endcase
  end

  // ====================
  // new value by funct3
  always_comb begin
    unique case (csr_op)
      OP_RW, OP_RWI: csr_wr_value = csr_wdata;
      OP_RS, OP_RSI: csr_wr_value = csr_rdata | csr_wdata;    // set bits
      OP_RC, OP_RCI: csr_wr_value = csr_rdata & ~csr_wdata;   // clear bits
      default:       csr_wr_value = csr_rdata;                // keep
    endcase
  end

endmodule

`default_nettype wire

/* hdl/csr_types_pkg.sv */
// csr types
// data word, address, privilege level, funct3 operation,
// trap cause and the internal register select

`default_nettype none

`include "csr_cfg.svh"

package csr_types_pkg;

  typedef logic [`CSR_XLEN-1:0] xlen_t;   // one csr data word
  typedef logic [11:0]          csr_addr_t;
  typedef logic [4:0]           cause_t;  // exception / interrupt code

  // privilege level, encoding as in the isa
  typedef enum logic [1:0] {
    PRIV_U = 2'd0,
    PRIV_S = 2'd1,
    PRIV_M = 2'd3
  } priv_t;

  // csr funct3
  typedef enum logic [2:0] {
    OP_RW  = 3'b001,
    OP_RS  = 3'b010,
    OP_RC  = 3'b011,
    OP_RWI = 3'b101,
    OP_RSI = 3'b110,
    OP_RCI = 3'b111
  } csr_op_t;

  // implemented registers, ID_NONE for anything else
  typedef enum logic [3:0] {
    ID_NONE, ID_MSTATUS, ID_MISA, ID_MIE, ID_MTVEC, ID_MSCRATCH, ID_MEPC,
    ID_MCAUSE, ID_MTVAL, ID_MIP, ID_MVENDORID, ID_MARCHID, ID_MIMPID, ID_MHARTID
  } csr_id_t;

endpackage

`default_nettype wire

/* hdl/irq_regs.sv */
// interrupt enable and pending registers
// mie is fully writable; mip keeps the software bits and
// shows msip, mtip and meip straight from the pins

`timescale 1ns/1ps
`default_nettype none

module irq_regs (
  input  wire                         clk,
  input  wire                         reset_n,
  input  wire csr_types_pkg::csr_id_t csr_sel,
  input  wire logic                   csr_wr_en,
  input  wire csr_types_pkg::xlen_t   csr_wr_value,
  input  wire logic                   mtip_in,   // clint timer
  input  wire logic                   msip_in,   // clint software
  input  wire logic                   meip_in,   // plic external
  output csr_types_pkg::xlen_t        mie_val,
  output csr_types_pkg::xlen_t        mip_val
);

  import csr_types_pkg::*;
  import csr_map_pkg::*;

  xlen_t mip_sw_q;   // hw bit positions always 0 here
  xlen_t mip_hw;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      mie_val  <= '0;
      mip_sw_q <= '0;
    end else if (csr_wr_en) begin
      if (csr_sel == ID_MIE) mie_val  <= csr_wr_value;
      if (csr_sel == ID_MIP) mip_sw_q <= csr_wr_value & ~MIP_HW_MASK;  // drop pin bits
    end
  end

  // ====================
  // pin merge, no register stage
  always_comb begin
    mip_hw = '0;
    mip_hw[IRQ_MSI_BIT] = msip_in;
    mip_hw[IRQ_MTI_BIT] = mtip_in;
    mip_hw[IRQ_MEI_BIT] = meip_in;
  end

  assign mip_val = mip_sw_q | mip_hw;

endmodule

`default_nettype wire

/* hdl/mstatus_reg.sv */
// mstatus register
// keeps mie, mpie and mpp; trap entry stacks the enable,
// mret unstacks it, csr writes reach the three fields only

`timescale 1ns/1ps
`default_nettype none

module mstatus_reg (
  input  wire                         clk,
  input  wire                         reset_n,
  input  wire csr_types_pkg::csr_id_t csr_sel,
  input  wire logic                   csr_wr_en,
  input  wire csr_types_pkg::xlen_t   csr_wr_value,
  input  wire logic                   trap_entry,
  input  wire logic                   mret,
  input  wire csr_types_pkg::priv_t   current_priv,
  output csr_types_pkg::xlen_t        mstatus_val,
  output logic                        mstatus_mie,
  output logic                        mstatus_mpie,
  output csr_types_pkg::priv_t        mpp_out
);

  import csr_types_pkg::*;
  import csr_map_pkg::*;

  logic  mie_q;
  logic  mpie_q;
  priv_t mpp_q;

  // trap > mret > csr write
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      mie_q  <= 1'b0;
      mpie_q <= 1'b0;
      mpp_q  <= PRIV_M;   // come out of reset in m mode
    end else if (trap_entry) begin
      mpie_q <= mie_q;
      mie_q  <= 1'b0;     // handler starts with interrupts off
      mpp_q  <= current_priv;
    end else if (mret) begin
      mie_q  <= mpie_q;
      mpie_q <= 1'b1;
      mpp_q  <= PRIV_U;   // lowest supported mode
    end else if (csr_wr_en && (csr_sel == ID_MSTATUS)) begin
      mie_q  <= csr_wr_value[MSTATUS_MIE_BIT];
      mpie_q <= csr_wr_value[MSTATUS_MPIE_BIT];
      mpp_q  <= priv_t'(csr_wr_value[MSTATUS_MPP_MSB:MSTATUS_MPP_LSB]);
    end
  end

  // full word, unimplemented fields read 0
  always_comb begin
    mstatus_val = '0;
    mstatus_val[MSTATUS_MIE_BIT]  = mie_q;
    mstatus_val[MSTATUS_MPIE_BIT] = mpie_q;
    mstatus_val[MSTATUS_MPP_MSB:MSTATUS_MPP_LSB] = mpp_q;
  end

  assign mstatus_mie  = mie_q;
  assign mstatus_mpie = mpie_q;
  assign mpp_out      = mpp_q;

endmodule

`default_nettype wire

/* hdl/trap_regs.sv */
// trap handling registers
// mtvec, mscratch, mepc, mcause and mtval; trap entry captures
// pc, cause and value ahead of any csr write to those three

`timescale 1ns/1ps
`default_nettype none

`include "csr_cfg.svh"

module trap_regs (
  input  wire                         clk,
  input  wire                         reset_n,
  input  wire csr_types_pkg::csr_id_t csr_sel,
  input  wire logic                   csr_wr_en,
  input  wire csr_types_pkg::xlen_t   csr_wr_value,
  input  wire logic                   trap_entry,
  input  wire csr_types_pkg::xlen_t   trap_pc,
  input  wire csr_types_pkg::xlen_t   trap_val,
  input  wire csr_types_pkg::cause_t  trap_cause,
  input  wire logic                   trap_is_interrupt,
  output csr_types_pkg::xlen_t        mtvec_val,
  output csr_types_pkg::xlen_t        mscratch_val,
  output csr_types_pkg::xlen_t        mepc_val,
  output csr_types_pkg::xlen_t        mcause_val,
  output csr_types_pkg::xlen_t        mtval_val
);

  import csr_types_pkg::*;

  // clears the low alignment bits of mtvec
  localparam xlen_t TVEC_MASK = ~xlen_t'((1 << `CSR_TVEC_ALIGN_BITS) - 1);

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      mtvec_val    <= '0;
      mscratch_val <= '0;
      mepc_val     <= '0;
      mcause_val   <= '0;
      mtval_val    <= '0;
    end else begin
      // not touched by a trap, a write always lands
      if (csr_wr_en && (csr_sel == ID_MTVEC))    mtvec_val    <= csr_wr_value & TVEC_MASK;
      if (csr_wr_en && (csr_sel == ID_MSCRATCH)) mscratch_val <= csr_wr_value;

      if (trap_entry) begin
        mepc_val   <= trap_pc;
        mcause_val <= {trap_is_interrupt, {(`CSR_XLEN-6){1'b0}}, trap_cause};
        mtval_val  <= trap_val;   // faulting address or instruction
      end else if (csr_wr_en) begin
        case (csr_sel)
          ID_MEPC:   mepc_val   <= {csr_wr_value[`CSR_XLEN-1:1], 1'b0};  // halfword aligned
          ID_MCAUSE: mcause_val <= csr_wr_value;
          ID_MTVAL:  mtval_val  <= csr_wr_value;
          default:   ;
        endcase
      end
    end
  end

endmodule

`default_nettype wire

/* include/csr_cfg.svh */
// csr file configuration
// data width, hardwired identity values and trap vector alignment
// for the machine-mode csr block of an rv32 core

`ifndef CSR_CFG_SVH
`define CSR_CFG_SVH

// ====================
// datapath
`define CSR_XLEN 32                      // rv32 only

// ====================
// identity registers
`define CSR_MISA_VALUE 32'h4000_1101     // mxl=1, extensions i, m, a
`define CSR_MIMPID_VALUE 32'h0000_0001   // implementation id

// low bits forced to zero on an mtvec write
`define CSR_TVEC_ALIGN_BITS 2

`endif

/* run_sim.sh */
#!/bin/sh
# build and run the csr file testbench with verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f verilog.f --top-module csr_file_tb -o csr_file_sim

# the testbench itself reports an assertion failure, so let it run on after $error
out=$(./obj_dir/csr_file_sim +verilator+error+limit+10 2>&1 || true)
echo "$out"

if echo "$out" | grep -qx "Testbench passed"; then
  exit 0
fi
exit 1

/* verification/csr_file_checker.sv */
// csr file assertions
// bound into the top level, watches the illegal flag,
// the enable stack on trap entry and mtvec alignment

`timescale 1ns/1ps
`default_nettype none

module csr_file_checker (
  input wire                       clk,
  input wire                       reset_n,
  input wire                       csr_access,
  input wire                       illegal_csr,
  input wire                       trap_entry,
  input wire                       mstatus_mie,
  input wire csr_types_pkg::xlen_t trap_vector
);

  int unsigned fail_count;   // read by the testbench

  initial fail_count = 0;

  // ====================
  // no illegal flag without a request
  a_illegal_needs_access: assert property (@(posedge clk) disable iff (!reset_n)
    !csr_access |-> !illegal_csr)
  else begin
    fail_count = fail_count + 1;
    $error("illegal_csr high while csr_access is low");
  end

  // handler always starts with interrupts off
  a_trap_clears_mie: assert property (@(posedge clk) disable iff (!reset_n)
    trap_entry |=> !mstatus_mie)
  else begin
    fail_count = fail_count + 1;
    $error("mstatus_mie still set the cycle after trap_entry");
  end

  a_tvec_aligned: assert property (@(posedge clk) disable iff (!reset_n)
    trap_vector[1:0] == 2'b00)   // direct mode, word aligned
  else begin
    fail_count = fail_count + 1;
    $error("trap_vector low bits not zero");
  end

endmodule

`default_nettype wire

/* verification/csr_file_tb.sv */
// csr file testbench
// random csr traffic, traps, mret and interrupt pins checked
// against a shadow model of the machine registers

`timescale 1ns/1ps
`default_nettype none

module csr_file_tb;

  import csr_types_pkg::*;
  import csr_map_pkg::*;

  localparam xlen_t MSTATUS_WMASK = 32'h0000_1888;  // mpp, mpie, mie
  localparam xlen_t PIN_MASK      = 32'h0000_0888;  // msip, mtip, meip

  logic      clk;
  logic      reset_n;
  csr_addr_t csr_addr;
  xlen_t     csr_wdata;
  csr_op_t   csr_op;
  logic      csr_we, csr_access;
  priv_t     current_priv;
  xlen_t     csr_rdata;
  logic      illegal_csr;
  logic      trap_entry, trap_is_interrupt, mret;
  xlen_t     trap_pc, trap_val, trap_vector, mepc_out;
  cause_t    trap_cause;
  logic      mstatus_mie, mstatus_mpie;
  priv_t     mpp_out;
  logic      mtip_in, msip_in, meip_in;
  xlen_t     mip_out, mie_out;

  // shadow registers of the model
  xlen_t m_mstatus, m_mie, m_mip_sw, m_mtvec, m_mscratch, m_mepc, m_mcause, m_mtval;
  csr_addr_t   addr;

  csr_file DUT (.*);

  bind csr_file csr_file_checker u_checker (
    .clk         (clk),
    .reset_n     (reset_n),
    .csr_access  (csr_access),
    .illegal_csr (illegal_csr),
    .trap_entry  (trap_entry),
    .mstatus_mie (mstatus_mie),
    .trap_vector (trap_vector)
  );

  always #4 clk = ~clk;  // 8 ns

  // ====================
  // reporting
  task automatic abort_run(input string what);
    $display("Testbench failed");
    $fatal(1, what);
  endtask

  task automatic check_value(input string name, input xlen_t actual, input xlen_t expected);
    if (actual !== expected) begin
      $display("MISMATCH %s: actual 0x%08h expected 0x%08h", name, actual, expected);
      abort_run("value mismatch");
    end
  endtask

  // a bound assertion failed on the last edge
  always @(negedge clk) begin
    if (DUT.u_checker.fail_count != 0) abort_run("an assertion in csr_file_checker failed");
  end

  // ====================
  // model
  function automatic xlen_t pin_bits();
    xlen_t v;
    v     = '0;
    v[3]  = msip_in;
    v[7]  = mtip_in;
    v[11] = meip_in;
    return v;
  endfunction

  function automatic csr_addr_t impl_addr(input int i);
    case (i)
      0: return CSR_MSTATUS;
      1: return CSR_MIE;
      2: return CSR_MTVEC;
      3: return CSR_MSCRATCH;
      4: return CSR_MEPC;
      5: return CSR_MCAUSE;
      6: return CSR_MTVAL;
      7: return CSR_MIP;     // last writable one
      8: return CSR_MISA;
      9: return CSR_MVENDORID;
      10: return CSR_MARCHID;
      11: return CSR_MIMPID;
      default: return CSR_MHARTID;
    endcase
  endfunction

  function automatic logic is_implemented(input csr_addr_t a);
    for (int i = 0; i < 13; i++) begin
      if (impl_addr(i) == a) return 1'b1;
    end
    return 1'b0;
  endfunction

  function automatic xlen_t model_read(input csr_addr_t a);
    case (a)
      CSR_MSTATUS:  return m_mstatus;
      CSR_MISA:     return 32'h4000_1101;   // rv32 ima
      CSR_MIE:      return m_mie;
      CSR_MTVEC:    return m_mtvec;
      CSR_MSCRATCH: return m_mscratch;
      CSR_MEPC:     return m_mepc;
      CSR_MCAUSE:   return m_mcause;
      CSR_MTVAL:    return m_mtval;
      CSR_MIP:      return m_mip_sw | pin_bits();
      CSR_MIMPID:   return 32'h0000_0001;
      default:      return '0;
    endcase
  endfunction

  function automatic void model_write(input csr_addr_t a, input xlen_t v);
    case (a)
      CSR_MSTATUS:  m_mstatus  = v & MSTATUS_WMASK;
      CSR_MIE:      m_mie      = v;
      CSR_MTVEC:    m_mtvec    = v & 32'hFFFF_FFFC;  // 4-byte aligned
      CSR_MSCRATCH: m_mscratch = v;
      CSR_MEPC:     m_mepc     = v & 32'hFFFF_FFFE;
      CSR_MCAUSE:   m_mcause   = v;
      CSR_MTVAL:    m_mtval    = v;
      CSR_MIP:      m_mip_sw   = v & ~PIN_MASK;      // pins win
      default:      ;
    endcase
  endfunction

  function automatic xlen_t op_result(input csr_op_t op, input xlen_t old, input xlen_t data);
    case (op)
      OP_RW, OP_RWI: return data;
      OP_RS, OP_RSI: return old | data;
      default:       return old & ~data;
    endcase
  endfunction

  function automatic csr_op_t pick_op();
    case ($urandom_range(5, 0))
      0: return OP_RW;
      1: return OP_RS;
      2: return OP_RC;
      3: return OP_RWI;
      4: return OP_RSI;
      default: return OP_RCI;
    endcase
  endfunction

  function automatic priv_t pick_priv();
    case ($urandom_range(2, 0))
      0: return PRIV_U;
      1: return PRIV_S;
      default: return PRIV_M;
    endcase
  endfunction

  // ====================
  // stimulus
  task automatic csr_cmd(input csr_addr_t a, input csr_op_t op, input xlen_t data,
                         input logic we, input priv_t priv,
                         output xlen_t rd, output logic ill);
    @(posedge clk);
    csr_addr     <= a;
    csr_op       <= op;
    csr_wdata    <= data;
    csr_we       <= we;
    csr_access   <= 1'b1;
    current_priv <= priv;
    trap_entry   <= 1'b0;
    mret         <= 1'b0;
    @(negedge clk);   // combinational outputs settled
    rd  = csr_rdata;
    ill = illegal_csr;
  endtask

  task automatic csr_idle();
    @(posedge clk);
    csr_access <= 1'b0;
    csr_we     <= 1'b0;
    trap_entry <= 1'b0;
    mret       <= 1'b0;
  endtask

  // legal m-mode access, old value checked, model takes the write
  task automatic legal_op(input csr_addr_t a, input csr_op_t op, input xlen_t data,
                          input logic we);
    xlen_t rd;
    xlen_t old;
    logic  ill;
    csr_cmd(a, op, data, we, PRIV_M, rd, ill);
    old = model_read(a);
    check_value("illegal_csr", xlen_t'(ill), 32'd0);
    check_value($sformatf("csr_rdata[%03h]", a), rd, old);
    if (we) model_write(a, op_result(op, old, data));
  endtask

  task automatic illegal_op(input csr_addr_t a, input logic we, input priv_t priv,
                            input logic reads_zero);
    xlen_t rd;
    logic  ill;
    csr_cmd(a, pick_op(), $urandom(), we, priv, rd, ill);
    check_value($sformatf("illegal_csr[%03h]", a), xlen_t'(ill), 32'd1);
    if (reads_zero) check_value("csr_rdata", rd, 32'd0);
  endtask

  task automatic check_outputs();
    check_value("mstatus_mie", xlen_t'(mstatus_mie), xlen_t'(m_mstatus[3]));
    check_value("mstatus_mpie", xlen_t'(mstatus_mpie), xlen_t'(m_mstatus[7]));
    check_value("mpp_out", xlen_t'(mpp_out), xlen_t'(m_mstatus[12:11]));
    check_value("trap_vector", trap_vector, m_mtvec);
    check_value("mepc_out", mepc_out, m_mepc);
    check_value("mie_out", mie_out, m_mie);
    check_value("mip_out", mip_out, m_mip_sw | pin_bits());
  endtask

  task automatic read_back(input csr_addr_t a);
    legal_op(a, OP_RS, '0, 1'b0);   // csrrs with x0, no write
    check_outputs();
  endtask

  task automatic check_all();
    for (int i = 0; i < 13; i++) legal_op(impl_addr(i), OP_RS, '0, 1'b0);
    check_outputs();
  endtask

  // trap and/or mret, with an optional mscratch or mepc write alongside
  task automatic trap_cycle(input logic do_trap, input logic do_mret, input logic side_wr);
    xlen_t     pc;
    xlen_t     val;
    xlen_t     data;
    cause_t    cause;
    logic      intr;
    priv_t     priv;
    csr_addr_t side_addr;
    logic      mie_old;
    logic      mpie_old;
    pc        = $urandom();
    val       = $urandom();
    data      = $urandom();
    cause     = 5'($urandom());
    intr      = 1'($urandom());
    priv      = pick_priv();
    side_addr = ($urandom_range(1, 0) == 0) ? CSR_MSCRATCH : CSR_MEPC;
    @(posedge clk);
    trap_entry        <= do_trap;
    mret              <= do_mret;
    trap_pc           <= pc;
    trap_val          <= val;
    trap_cause        <= cause;
    trap_is_interrupt <= intr;
    current_priv      <= priv;
    csr_addr          <= side_addr;
    csr_op            <= OP_RW;
    csr_wdata         <= data;
    csr_we            <= side_wr;
    csr_access        <= side_wr;
    // model in priority order, trap over mret over csr write
    if (side_wr && priv == PRIV_M) model_write(side_addr, data);
    mie_old  = m_mstatus[3];
    mpie_old = m_mstatus[7];
    if (do_trap) begin
      m_mepc            = pc;
      m_mcause          = {intr, 26'd0, cause};
      m_mtval           = val;
      m_mstatus[7]      = mie_old;
      m_mstatus[3]      = 1'b0;
      m_mstatus[12:11]  = priv;
    end else if (do_mret) begin
      m_mstatus[3]      = mpie_old;
      m_mstatus[7]      = 1'b1;
      m_mstatus[12:11]  = 2'b00;    // back to u
    end
    csr_idle();
    @(negedge clk);
    check_outputs();
  endtask

  // pins and an mip write in the same cycle
  task automatic pin_cycle();
    xlen_t data;
    data = $urandom();
    @(posedge clk);
    msip_in      <= 1'($urandom());
    mtip_in      <= 1'($urandom());
    meip_in      <= 1'($urandom());
    csr_addr     <= CSR_MIP;
    csr_op       <= OP_RW;
    csr_wdata    <= data;
    csr_we       <= 1'b1;
    csr_access   <= 1'b1;
    current_priv <= PRIV_M;
    @(negedge clk);
    check_value("mip_out", mip_out, m_mip_sw | pin_bits());
    check_value("csr_rdata[mip]", csr_rdata, m_mip_sw | pin_bits());
    model_write(CSR_MIP, data);
    read_back(CSR_MIP);
  endtask

  // ====================
  // main sequence
  initial begin
    void'($urandom(32'h1662));
    clk               = 1'b0;
    reset_n           = 1'b0;
    csr_addr          = '0;
    csr_wdata         = '0;
    csr_op            = OP_RW;
    csr_we            = 1'b0;
    csr_access        = 1'b0;
    current_priv      = PRIV_M;
    trap_entry        = 1'b0;
    trap_pc           = '0;
    trap_cause        = '0;
    trap_is_interrupt = 1'b0;
    trap_val          = '0;
    mret              = 1'b0;
    mtip_in           = 1'b0;
    msip_in           = 1'b0;
    meip_in           = 1'b0;
    {m_mie, m_mip_sw, m_mtvec, m_mscratch, m_mepc, m_mcause, m_mtval} = '0;
    m_mstatus = 32'h0000_1800;   // mpp = m

    repeat (8) @(posedge clk);
    reset_n <= 1'b1;
    check_all();

    repeat (300) begin
      csr_op_t op;
      xlen_t   data;
      addr = impl_addr(int'($urandom_range(7, 0)));
      op   = pick_op();
      data = $urandom();
      if (op inside {OP_RWI, OP_RSI, OP_RCI}) data = data & 32'h1F;   // uimm
      legal_op(addr, op, data, 1'b1);
      read_back(addr);
    end

    repeat (100) begin
      case ($urandom_range(2, 0))
        0: begin
          do addr = 12'($urandom()); while (is_implemented(addr));
          illegal_op(addr, 1'($urandom()), pick_priv(), 1'b1);
        end
        1: illegal_op(impl_addr(int'($urandom_range(12, 0))), 1'($urandom()),
                      ($urandom_range(1, 0) == 0) ? PRIV_U : PRIV_S, 1'b0);
        default: illegal_op(impl_addr(int'($urandom_range(12, 8))), 1'b1, PRIV_M, 1'b0);
      endcase
    end
    check_all();

    // trap only, mret only, then both together
    for (int k = 0; k < 90; k++) begin
      legal_op(CSR_MSTATUS, OP_RW, $urandom(), 1'b1);
      trap_cycle(k < 40 || k >= 70, k >= 40, 1'($urandom()));
      check_all();
    end

    repeat (50) pin_cycle();

    csr_idle();
    @(negedge clk);
    if (DUT.u_checker.fail_count == 0) begin
      $display("Testbench passed");
      $finish;
    end else begin
      abort_run("an assertion in csr_file_checker failed");
    end
  end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+include
hdl/csr_types_pkg.sv
hdl/csr_map_pkg.sv
hdl/csr_decode.sv
hdl/csr_rw_datapath.sv
hdl/mstatus_reg.sv
hdl/trap_regs.sv
hdl/irq_regs.sv
hdl/csr_file.sv
verification/csr_file_checker.sv
verification/csr_file_tb.sv
